// File: verilog/riscv_isa_pkg.sv
/* RV32I encoding used by the core. Holds data and field types, opcode and funct
   constants and the instruction format enum, imported by the decoder and execute logic */
`default_nettype none

package riscv_isa_pkg;

    typedef logic [31:0] word_t;       // Register values, immediates, PCs
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] inst_word_t;  // Raw instruction
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // Opcodes of the supported subset
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    // Arithmetic funct3, shared by OP and OP_IMM
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;  // SRL or SRA by funct7
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // Branch compares
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam funct7_t F7_ALT = 7'b0100000;  // SUB, SRA, SRAI

    typedef enum logic [2:0] {
        TYPE_R,
        TYPE_I,
        TYPE_B,
        TYPE_U,
        TYPE_J,
        TYPE_N   // Not supported
    } inst_type_t;

endpackage

`default_nettype wire

// File: verilog/core_pkg.sv
/* Core-internal types passed between decode, execute and commit, plus the reset PC
   and the sequential PC step */
`default_nettype none

package core_pkg;

    import riscv_isa_pkg::*;

    localparam word_t RESET_PC   = 32'h8000_0000;
    localparam word_t XLEN_BYTES = 32'd4;  // Sequential PC step

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef struct packed {
        opcode_t    opcode;
        funct3_t    funct3;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        word_t      imm;        // Sign extended where the format asks
        inst_type_t inst_type;
        alu_op_t    alu_op;
        logic       illegal;
    } decoded_t;

    typedef struct packed {
        word_t alu_result;
        word_t jump_target;
        logic  jump_en;
    } exec_result_t;

    typedef struct packed {
        word_t    pc;       // Address of the retired instruction
        reg_idx_t rd;
        word_t    data;
        logic     we;
        logic     illegal;
    } retire_t;

endpackage

`default_nettype wire

// File: verilog/inst_decoder.sv
/* Combinational RV32I decoder. Splits the instruction word into fields, classifies
   the format, builds the immediate and picks the ALU operation */
`default_nettype none
`timescale 1ns/10ps

module inst_decoder import riscv_isa_pkg::*, core_pkg::*; (
    input  inst_word_t inst,
    output decoded_t   dec
);

    opcode_t    opcode;
    funct3_t    funct3;
    funct7_t    funct7;
    inst_type_t inst_type;
    word_t      imm;
    alu_op_t    alu_op;
    logic       illegal;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        illegal = 1'b0;
        case (opcode)
            OPC_OP:               inst_type = TYPE_R;
            OPC_OP_IMM, OPC_JALR: inst_type = TYPE_I;
            OPC_BRANCH:           inst_type = TYPE_B;
            OPC_LUI, OPC_AUIPC:   inst_type = TYPE_U;
            OPC_JAL:              inst_type = TYPE_J;
            default: begin        // Loads, stores, SYSTEM and unknown
                inst_type = TYPE_N;
                illegal   = 1'b1;
            end
        endcase
    end

    always_comb begin
        case (inst_type)
            TYPE_I:  imm = {{20{inst[31]}}, inst[31:20]};
            TYPE_B:  imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            TYPE_U:  imm = {inst[31:12], 12'b0};
            TYPE_J:  imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    // Everything outside OP and OP_IMM adds
    always_comb begin
        alu_op = ALU_ADD;
        if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
            case (funct3)
                F3_ADD:  if (opcode == OPC_OP && funct7 == F7_ALT) alu_op = ALU_SUB;
                F3_SLL:  alu_op = ALU_SLL;
                F3_SLT:  alu_op = ALU_SLT;
                F3_SLTU: alu_op = ALU_SLTU;
                F3_XOR:  alu_op = ALU_XOR;
                F3_SR:   alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                F3_OR:   alu_op = ALU_OR;
                F3_AND:  alu_op = ALU_AND;
            endcase
        end
    end

    always_comb begin
        dec.opcode    = opcode;
        dec.funct3    = funct3;
        dec.rd        = inst[11:7];
        dec.rs1       = inst[19:15];
        dec.rs2       = inst[24:20];
        dec.imm       = imm;
        dec.inst_type = inst_type;
        dec.alu_op    = alu_op;
        dec.illegal   = illegal;
    end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
/* General register file with two combinational read ports and one clocked write
   port. x0 is never written, so it always reads zero */
`default_nettype none
`timescale 1ns/10ps

module reg_file import riscv_isa_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     we,
    input  reg_idx_t rd,
    input  word_t    wdata
);

    word_t regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin  // Writes to x0 dropped
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

// File: verilog/exec_unit.sv
/* Combinational execute stage. Picks ALU operands by format, runs the ALU and
   resolves branches, JAL and JALR into a jump target and enable */
`default_nettype none
`timescale 1ns/10ps

module exec_unit import riscv_isa_pkg::*, core_pkg::*; (
    input  decoded_t     dec,
    input  word_t        pc,
    input  word_t        rs1_data,
    input  word_t        rs2_data,
    output exec_result_t ex
);

    word_t      alu_a;
    word_t      alu_b;
    word_t      alu_result;
    logic [4:0] shamt;
    logic       branch_taken;

    always_comb begin
        case (dec.inst_type)
            TYPE_U: begin
                alu_a = (dec.opcode == OPC_LUI) ? '0 : pc;  // LUI or AUIPC
                alu_b = dec.imm;
            end
            TYPE_J, TYPE_B: begin  // Target is pc relative
                alu_a = pc;
                alu_b = dec.imm;
            end
            TYPE_I: begin
                alu_a = rs1_data;
                alu_b = dec.imm;
            end
            default: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
        endcase
    end

    assign shamt = alu_b[4:0];

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  alu_result = alu_a + alu_b;
            ALU_SUB:  alu_result = alu_a - alu_b;
            ALU_SLL:  alu_result = alu_a << shamt;
            ALU_SLT:  alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU: alu_result = {31'b0, alu_a < alu_b};
            ALU_XOR:  alu_result = alu_a ^ alu_b;
            ALU_SRL:  alu_result = alu_a >> shamt;
            ALU_SRA:  alu_result = $signed(alu_a) >>> shamt;
            ALU_OR:   alu_result = alu_a | alu_b;
            ALU_AND:  alu_result = alu_a & alu_b;
            default:  alu_result = alu_a + alu_b;
        endcase
    end

    // Compare on register values, the ALU is busy with the target
    always_comb begin
        case (dec.funct3)
            F3_BEQ:  branch_taken = rs1_data == rs2_data;
            F3_BNE:  branch_taken = rs1_data != rs2_data;
            F3_BLT:  branch_taken = $signed(rs1_data) < $signed(rs2_data);
            F3_BGE:  branch_taken = $signed(rs1_data) >= $signed(rs2_data);
            F3_BLTU: branch_taken = rs1_data < rs2_data;
            F3_BGEU: branch_taken = rs1_data >= rs2_data;
            default: branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        ex.alu_result  = alu_result;
        ex.jump_target = alu_result;
        ex.jump_en     = 1'b0;
        case (dec.inst_type)
            TYPE_J: ex.jump_en = 1'b1;
            TYPE_B: ex.jump_en = branch_taken;
            TYPE_I: begin
                if (dec.opcode == OPC_JALR) begin
                    ex.jump_en     = 1'b1;
                    ex.jump_target = {alu_result[31:1], 1'b0};
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/commit_unit.sv
/* Commit stage. Drives the register write-back, holds the PC register and captures
   the retire record on every accepted instruction */
`default_nettype none
`timescale 1ns/10ps

module commit_unit import riscv_isa_pkg::*, core_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         inst_valid,
    input  decoded_t     dec,
    input  exec_result_t ex,
    output word_t        pc,
    output logic         rf_we,
    output reg_idx_t     rf_rd,
    output word_t        rf_wdata,
    output logic         retire_valid,
    output retire_t      retire
);

    word_t seq_pc;
    word_t next_pc;
    logic  is_link;
    logic  rd_written;  // Architectural register actually changes

    assign seq_pc  = pc + XLEN_BYTES;
    assign is_link = dec.opcode == OPC_JAL || dec.opcode == OPC_JALR;
    assign next_pc = ex.jump_en ? ex.jump_target : seq_pc;

    // Branches and illegal opcodes write nothing
    assign rf_we      = inst_valid && !dec.illegal && dec.inst_type != TYPE_B;
    assign rf_rd      = dec.rd;
    assign rf_wdata   = is_link ? seq_pc : ex.alu_result;
    assign rd_written = rf_we && rf_rd != '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc           <= RESET_PC;
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= inst_valid;  // One cycle per accepted instruction
            if (inst_valid) begin
                pc <= next_pc;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            retire <= '0;
        end else if (inst_valid) begin
            retire.pc      <= pc;
            retire.rd      <= dec.rd;
            retire.data    <= rd_written ? rf_wdata : '0;
            retire.we      <= rd_written;
            retire.illegal <= dec.illegal;
        end
    end

endmodule

`default_nettype wire

// File: verilog/rv_core.sv
/* Single-cycle RV32I integer core. Takes one instruction per inst_valid strobe and
   reports it on the retire port in the following cycle */
`default_nettype none
`timescale 1ns/10ps

module rv_core import riscv_isa_pkg::*, core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       inst_valid,
    input  inst_word_t inst,
    output word_t      pc,
    output logic       retire_valid,
    output retire_t    retire
);

    decoded_t     dec;
    exec_result_t ex;
    word_t        rs1_data;
    word_t        rs2_data;
    logic         rf_we;
    reg_idx_t     rf_rd;
    word_t        rf_wdata;

    inst_decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rf_we),
        .rd       (rf_rd),
        .wdata    (rf_wdata)
    );

    exec_unit u_exec (
        .dec      (dec),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .ex       (ex)
    );

    commit_unit u_commit (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .dec          (dec),
        .ex           (ex),
        .pc           (pc),
        .rf_we        (rf_we),
        .rf_rd        (rf_rd),
        .rf_wdata     (rf_wdata),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

`default_nettype wire

// File: sim/rv_core_assert.sv
/* Protocol checks on the core's retire port, bound into every rv_core instance */
`default_nettype none
`timescale 1ns/10ps

module rv_core_assert import core_pkg::*; (
    input logic    clk,
    input logic    reset,
    input logic    inst_valid,
    input logic    retire_valid,
    input retire_t retire
);

    int failures = 0;  // Read by the testbench at the end

    // A retire pulse needs a fresh strobe behind it
    no_stale_retire: assert property (@(posedge clk) disable iff (reset)
        retire_valid && !inst_valid |=> !retire_valid)
        else begin
            $error("retire_valid held without a new inst_valid");
            failures++;
        end

    no_x0_write: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> !(retire.we && retire.rd == '0))
        else begin
            $error("retired write targets x0");
            failures++;
        end

    no_illegal_write: assert property (@(posedge clk) disable iff (reset)
        retire_valid && retire.illegal |-> !retire.we)
        else begin
            $error("illegal instruction retired with a register write");
            failures++;
        end

endmodule

bind rv_core rv_core_assert u_assert (
    .clk          (clk),
    .reset        (reset),
    .inst_valid   (inst_valid),
    .retire_valid (retire_valid),
    .retire       (retire)
);

`default_nettype wire

// File: sim/rv_core_tb.sv
/* Testbench for the RV32I core. Applies a hand-computed instruction table, one strobe
   per row, and checks the retire port and pc after each accepted instruction */
`default_nettype none
`timescale 1ns/10ps

module rv_core_tb import riscv_isa_pkg::*, core_pkg::*; ();

    localparam int NUM_ROWS = 36;

    typedef struct packed {
        inst_word_t inst;
        reg_idx_t   rd;
        word_t      data;
        logic       we;
        logic       illegal;
        word_t      next_pc;
    } vector_t;

    logic       clk;
    logic       reset;
    logic       inst_valid;
    inst_word_t inst;
    word_t      pc;
    logic       retire_valid;
    retire_t    retire;

    vector_t rows [NUM_ROWS];
    int      errors;
    int      checks;
    word_t   prev_pc;  // Address of the instruction in flight

    rv_core dut (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .pc           (pc),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (NUM_ROWS * 3 + 20) @(posedge clk);
        $display("timeout: instruction table did not complete in time");
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic compare(input string name, input word_t exp, input word_t got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("error %s exp %h got %h", name, exp, got);
        end
    endtask

    // Starts at 32'h8000_0000; x1 = 5 and x2 = -3 feed most later rows
    task automatic load_table();
        rows[0]  = '{32'h0050_0093, 5'd1,  32'h0000_0005, 1'b1, 1'b0, 32'h8000_0004}; // addi x1
        rows[1]  = '{32'hFFD0_0113, 5'd2,  32'hFFFF_FFFD, 1'b1, 1'b0, 32'h8000_0008}; // addi x2
        rows[2]  = '{32'h0020_81B3, 5'd3,  32'h0000_0002, 1'b1, 1'b0, 32'h8000_000C}; // add
        rows[3]  = '{32'h4020_8233, 5'd4,  32'h0000_0008, 1'b1, 1'b0, 32'h8000_0010}; // sub
        rows[4]  = '{32'h0011_22B3, 5'd5,  32'h0000_0001, 1'b1, 1'b0, 32'h8000_0014}; // slt
        rows[5]  = '{32'h0011_3333, 5'd6,  32'h0000_0000, 1'b1, 1'b0, 32'h8000_0018}; // sltu
        rows[6]  = '{32'h0020_C3B3, 5'd7,  32'hFFFF_FFF8, 1'b1, 1'b0, 32'h8000_001C}; // xor
        rows[7]  = '{32'h0020_E433, 5'd8,  32'hFFFF_FFFD, 1'b1, 1'b0, 32'h8000_0020}; // or
        rows[8]  = '{32'h0020_F4B3, 5'd9,  32'h0000_0005, 1'b1, 1'b0, 32'h8000_0024}; // and
        rows[9]  = '{32'h0030_9533, 5'd10, 32'h0000_0014, 1'b1, 1'b0, 32'h8000_0028}; // sll
        rows[10] = '{32'h0031_55B3, 5'd11, 32'h3FFF_FFFF, 1'b1, 1'b0, 32'h8000_002C}; // srl
        rows[11] = '{32'h4031_5633, 5'd12, 32'hFFFF_FFFF, 1'b1, 1'b0, 32'h8000_0030}; // sra
        rows[12] = '{32'h0001_2693, 5'd13, 32'h0000_0001, 1'b1, 1'b0, 32'h8000_0034}; // slti
        rows[13] = '{32'h0060_B713, 5'd14, 32'h0000_0001, 1'b1, 1'b0, 32'h8000_0038}; // sltiu
        rows[14] = '{32'hFFF0_C793, 5'd15, 32'hFFFF_FFFA, 1'b1, 1'b0, 32'h8000_003C}; // xori
        rows[15] = '{32'h0F00_E813, 5'd16, 32'h0000_00F5, 1'b1, 1'b0, 32'h8000_0040}; // ori
        rows[16] = '{32'h0FF1_7893, 5'd17, 32'h0000_00FD, 1'b1, 1'b0, 32'h8000_0044}; // andi
        rows[17] = '{32'h0040_9913, 5'd18, 32'h0000_0050, 1'b1, 1'b0, 32'h8000_0048}; // slli
        rows[18] = '{32'h01C1_5993, 5'd19, 32'h0000_000F, 1'b1, 1'b0, 32'h8000_004C}; // srli
        rows[19] = '{32'h4011_5A13, 5'd20, 32'hFFFF_FFFE, 1'b1, 1'b0, 32'h8000_0050}; // srai
        rows[20] = '{32'h1234_5AB7, 5'd21, 32'h1234_5000, 1'b1, 1'b0, 32'h8000_0054}; // lui
        rows[21] = '{32'h0000_1B17, 5'd22, 32'h8000_1054, 1'b1, 1'b0, 32'h8000_0058}; // auipc
        // Branch rd field holds offset bits and is never written
        rows[22] = '{32'h0090_8463, 5'd8,  32'h0000_0000, 1'b0, 1'b0, 32'h8000_0060}; // beq t
        rows[23] = '{32'h0090_9463, 5'd8,  32'h0000_0000, 1'b0, 1'b0, 32'h8000_0064}; // bne nt
        rows[24] = '{32'h0011_4663, 5'd12, 32'h0000_0000, 1'b0, 1'b0, 32'h8000_0070}; // blt t
        rows[25] = '{32'h0011_5663, 5'd12, 32'h0000_0000, 1'b0, 1'b0, 32'h8000_0074}; // bge nt
        rows[26] = '{32'h0011_6463, 5'd8,  32'h0000_0000, 1'b0, 1'b0, 32'h8000_0078}; // bltu nt
        rows[27] = '{32'hFE11_7CE3, 5'd25, 32'h0000_0000, 1'b0, 1'b0, 32'h8000_0070}; // bgeu t
        rows[28] = '{32'h0100_0BEF, 5'd23, 32'h8000_0074, 1'b1, 1'b0, 32'h8000_0080}; // jal
        rows[29] = '{32'h005B_8C67, 5'd24, 32'h8000_0084, 1'b1, 1'b0, 32'h8000_0078}; // jalr
        rows[30] = '{32'h0070_8013, 5'd0,  32'h0000_0000, 1'b0, 1'b0, 32'h8000_007C}; // addi x0
        rows[31] = '{32'h0010_0CB3, 5'd25, 32'h0000_0005, 1'b1, 1'b0, 32'h8000_0080}; // x0 + x1
        rows[32] = '{32'h0000_AD03, 5'd26, 32'h0000_0000, 1'b0, 1'b1, 32'h8000_0084}; // lw
        rows[33] = '{32'h0011_2023, 5'd0,  32'h0000_0000, 1'b0, 1'b1, 32'h8000_0088}; // sw
        rows[34] = '{32'h0000_0073, 5'd0,  32'h0000_0000, 1'b0, 1'b1, 32'h8000_008C}; // ecall
        rows[35] = '{32'h008D_0DB3, 5'd27, 32'hFFFF_FFFD, 1'b1, 1'b0, 32'h8000_0090}; // x26 + x8
    endtask

    initial begin
        errors     = 0;
        checks     = 0;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        load_table();
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;

        // Idle after reset until the first strobe
        compare("retire.pc", '0, retire.pc);
        compare("retire.rd", '0, word_t'(retire.rd));
        compare("retire.data", '0, retire.data);
        compare("retire.we", '0, word_t'(retire.we));
        compare("retire.illegal", '0, word_t'(retire.illegal));
        for (int c = 0; c < 2; c++) begin
            compare("pc", RESET_PC, pc);
            compare("retire_valid", '0, word_t'(retire_valid));
            @(posedge clk);
            #1;
        end

        prev_pc = RESET_PC;
        for (int i = 0; i < NUM_ROWS; i++) begin
            inst_valid = 1'b1;
            inst       = rows[i].inst;
            @(posedge clk);
            #1;
            inst_valid = 1'b0;
            inst       = '0;
            compare("retire_valid", 32'd1, word_t'(retire_valid));
            compare("retire.pc", prev_pc, retire.pc);
            compare("retire.rd", word_t'(rows[i].rd), word_t'(retire.rd));
            compare("retire.data", rows[i].data, retire.data);
            compare("retire.we", word_t'(rows[i].we), word_t'(retire.we));
            compare("retire.illegal", word_t'(rows[i].illegal), word_t'(retire.illegal));
            compare("pc", rows[i].next_pc, pc);
            prev_pc = rows[i].next_pc;
            if (i % 4 == 3) begin  // Gap cycle with nothing moving
                @(posedge clk);
                #1;
                compare("retire_valid", '0, word_t'(retire_valid));
                compare("pc", prev_pc, pc);
            end
        end

        $display("checks %0d errors %0d assertion failures %0d",
                 checks, errors, dut.u_assert.failures);
        if (errors == 0 && dut.u_assert.failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_core.f
verilog/riscv_isa_pkg.sv
verilog/core_pkg.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/exec_unit.sv
verilog/commit_unit.sv
verilog/rv_core.sv
sim/rv_core_assert.sv
sim/rv_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator, pass only on the status line
verilator --binary --timing --assert --top-module rv_core_tb -f rv_core.f || exit 1
output=$(./obj_dir/Vrv_core_tb +verilator+error+limit+100 2>&1)
echo "$output"
echo "$output" | grep -q "STATUS: PASS" && exit 0 || exit 1
